// File: rtl/vic20_load_defs.svh
// Constants for the default VIC-20 memory map only, with a 23-bit byte-wide external memory
`ifndef VIC20_LOAD_DEFS_SVH
`define VIC20_LOAD_DEFS_SVH

// ==============================
// External memory
// ==============================
`define VIC_MEM_AW        23
`define VIC_TAP_BASE      23'h020000
`define VIC_TAP_VER_OFS   24'd12

// PRG load window and pointer injection
`define VIC_CART_BASE     16'hA000
`define VIC_CART_TOP      16'hBFFF
`define VIC_INJ_LAST      5'd31

// Host file types on the download index
`define VIC_IDX_ROM       8'h00
`define VIC_IDX_PRG       8'h01
`define VIC_IDX_CRT       8'h41
`define VIC_IDX_TAP       8'h81

// ROM image regions, taken from byte position bits 15..13
`define VIC_RGN_DRIVE_LO  3'd0
`define VIC_RGN_DRIVE_HI  3'd1
`define VIC_RGN_KERN_PAL  3'd2
`define VIC_RGN_KERN_NTSC 3'd3
`define VIC_RGN_BASIC     3'd4
`define VIC_RGN_CHAR      3'd5

`endif

// File: rtl/vic20_load_pkg.sv
// Types shared by the loader blocks; memory addresses follow VIC_MEM_AW from the defs header
`include "vic20_load_defs.svh"

package vic20_load_pkg;

    // Download kind, decoded from the host index
    typedef enum logic [1:0] {
        NONE = 2'd0,
        ROM  = 2'd1,
        PRG  = 2'd2,
        TAP  = 2'd3
    } dl_kind_e;

    // Host download port
    typedef struct packed {
        logic        active;
        logic [7:0]  index;
        logic        wr;
        logic [23:0] addr;
        logic [7:0]  data;
    } dl_bus_t;

    // Load address, counted as a word and captured or injected as bytes
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } load_addr_u;

    typedef struct packed {
        logic [`VIC_MEM_AW-1:0] addr;
        logic [7:0]             din;
        logic                   we;
        logic                   oe;
    } mem_req_t;

    // Write on the machine's internal configuration bus
    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  data;
    } conf_wr_t;

endpackage

// File: rtl/load_addr_map.sv
// Combinational target decode; ROM positions past 64K or in unused regions map to address 0
`timescale 1ns/1ps
`include "vic20_load_defs.svh"

module load_addr_map (
    input  vic20_load_pkg::dl_kind_e   kind_i,
    input  logic [23:0]                dl_addr_i,
    input  vic20_load_pkg::load_addr_u prg_addr_i,
    input  logic [`VIC_MEM_AW-1:0]     tap_addr_i,
    input  logic                       inject_i,
    input  logic [15:0]                inj_addr_i,
    output logic [`VIC_MEM_AW-1:0]     target_o,
    output logic                       internal_o
);

    logic [2:0] rom_rgn;
    logic       rom_in_range;
    logic       prg_low_ram;

    assign rom_rgn      = dl_addr_i[15:13];
    assign rom_in_range = (dl_addr_i[23:16] == 8'h00);

    // Internal RAM windows: 1K low RAM, 4K main RAM and colour RAM
    assign prg_low_ram = (prg_addr_i.word[15:10] == 6'b000000) ||
                         (prg_addr_i.word[15:12] == 4'b0001) ||
                         (prg_addr_i.word[15:10] == 6'b100101);

    always_comb begin
        target_o = '0;
        if (inject_i) begin
            target_o = {7'h00, inj_addr_i};
        end else begin
            case (kind_i)
                vic20_load_pkg::ROM: begin
                    if (rom_in_range) begin
                        case (rom_rgn)
                            `VIC_RGN_DRIVE_LO,
                            `VIC_RGN_DRIVE_HI:  target_o = {9'h000, dl_addr_i[13:0]};
                            `VIC_RGN_KERN_PAL:  target_o = {7'h00, 3'b111, dl_addr_i[12:0]};
                            // NTSC kernal sits in the copy one 64K bank up
                            `VIC_RGN_KERN_NTSC: target_o = {7'h01, 3'b111, dl_addr_i[12:0]};
                            `VIC_RGN_BASIC:     target_o = {7'h00, 3'b110, dl_addr_i[12:0]};
                            `VIC_RGN_CHAR:      target_o = {7'h00, 4'b1000, dl_addr_i[11:0]};
                            default:            target_o = '0;
                        endcase
                    end
                end
                vic20_load_pkg::PRG: target_o = {7'h00, prg_addr_i.word};
                vic20_load_pkg::TAP: target_o = tap_addr_i;
                default:             target_o = '0;
            endcase
        end
    end

    // Char ROM, low RAM loads and pointer injection all use the internal bus
    assign internal_o = inject_i ||
                        (kind_i == vic20_load_pkg::ROM && rom_in_range &&
                         rom_rgn == `VIC_RGN_CHAR) ||
                        (kind_i == vic20_load_pkg::PRG && prg_low_ram);

endmodule

// File: rtl/prg_loader.sv
// PRG header is two little-endian bytes; loads stop at $BFFF and ROM positions keep 16 bits
`timescale 1ns/1ps
`include "vic20_load_defs.svh"

module prg_loader (
    input  logic                       clk_sys,
    input  logic                       reset,
    input  vic20_load_pkg::dl_bus_t    dl_i,
    input  logic                       no_load_addr_i,
    output vic20_load_pkg::dl_kind_e   kind_o,
    output vic20_load_pkg::load_addr_u prg_addr_o,
    output logic [`VIC_MEM_AW-1:0]     tap_addr_o,
    output logic                       inject_o,
    output logic [15:0]                inj_addr_o,
    output logic                       wr_o,
    output logic [7:0]                 data_o,
    output logic                       force_reset_o
);

    vic20_load_pkg::dl_kind_e kind_now;
    logic [4:0]               inj_step;
    logic                     prg_q;
    logic                     auto_reset;
    logic                     header_byte;
    logic                     byte_wr;
    logic                     inj_wr;

    always_comb begin
        kind_now = vic20_load_pkg::NONE;
        if (dl_i.active) begin
            case (dl_i.index)
                `VIC_IDX_ROM:              kind_now = vic20_load_pkg::ROM;
                `VIC_IDX_PRG, `VIC_IDX_CRT: kind_now = vic20_load_pkg::PRG;
                `VIC_IDX_TAP:              kind_now = vic20_load_pkg::TAP;
                default:                   kind_now = vic20_load_pkg::NONE;
            endcase
        end
    end

    // Bytes 0 and 1 carry the load address in header mode
    assign header_byte = !no_load_addr_i && (dl_i.addr[23:1] == 23'd0);
    assign byte_wr     = dl_i.wr && (kind_now != vic20_load_pkg::NONE) &&
                         !(kind_now == vic20_load_pkg::PRG && header_byte);
    // Odd steps 1..15 each write one pointer byte
    assign inj_wr      = inj_step[0] && !inj_step[4];
    assign inject_o    = (inj_step != 5'd0);

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            kind_o        <= vic20_load_pkg::NONE;
            prg_q         <= 1'b0;
            inj_step      <= 5'd0;
            auto_reset    <= 1'b0;
            wr_o          <= 1'b0;
            force_reset_o <= 1'b0;
        end else begin
            kind_o        <= kind_now;
            prg_q         <= (kind_now == vic20_load_pkg::PRG);
            wr_o          <= byte_wr || inj_wr;
            force_reset_o <= 1'b0;

            // A byte landing on the cartridge base arms the auto-reset
            if (wr_o && kind_o == vic20_load_pkg::PRG && prg_addr_o.word == `VIC_CART_BASE) begin
                auto_reset <= 1'b1;
            end

            if (prg_q && kind_now != vic20_load_pkg::PRG) begin
                inj_step <= 5'd1;
            end else if (inject_o) begin
                inj_step <= inj_step + 5'd1;
            end

            if (inj_step == `VIC_INJ_LAST) begin
                force_reset_o <= auto_reset;
                auto_reset    <= 1'b0;
            end
        end
    end

    // ==============================
    // Address counters and write data
    // ==============================
    always_ff @(posedge clk_sys) begin
        data_o <= dl_i.data;
        if (dl_i.wr) begin
            case (kind_now)
                vic20_load_pkg::ROM: prg_addr_o.word <= dl_i.addr[15:0];
                vic20_load_pkg::TAP: tap_addr_o <= `VIC_TAP_BASE + dl_i.addr[`VIC_MEM_AW-1:0];
                vic20_load_pkg::PRG: begin
                    if (no_load_addr_i) begin
                        if (dl_i.addr == 24'd0) begin
                            prg_addr_o.word <= `VIC_CART_BASE;
                        end else if (prg_addr_o.word != `VIC_CART_TOP) begin
                            prg_addr_o.word <= prg_addr_o.word + 16'd1;
                        end
                    end else if (dl_i.addr == 24'd0) begin
                        prg_addr_o.bytes.lo <= dl_i.data;
                    end else if (dl_i.addr == 24'd1) begin
                        prg_addr_o.bytes.hi <= dl_i.data;
                    end else if (dl_i.addr != 24'd2 && prg_addr_o.word != `VIC_CART_TOP) begin
                        prg_addr_o.word <= prg_addr_o.word + 16'd1;
                    end
                end
                default: ;
            endcase
        end

        if (inj_wr) begin
            data_o <= inj_step[1] ? prg_addr_o.bytes.hi : prg_addr_o.bytes.lo;
            // BASIC variable, array and end pointers, then the load end address
            case (inj_step[3:1])
                3'd0:    inj_addr_o <= 16'h002D;
                3'd1:    inj_addr_o <= 16'h002E;
                3'd2:    inj_addr_o <= 16'h002F;
                3'd3:    inj_addr_o <= 16'h0030;
                3'd4:    inj_addr_o <= 16'h0031;
                3'd5:    inj_addr_o <= 16'h0032;
                3'd6:    inj_addr_o <= 16'h00AE;
                default: inj_addr_o <= 16'h00AF;
            endcase
        end
    end

endmodule

// File: rtl/tape_fetch.sv
// Plays from VIC_TAP_BASE through the last stored byte, at most one byte per p2 low phase
`timescale 1ns/1ps
`include "vic20_load_defs.svh"

module tape_fetch (
    input  logic                    clk_sys,
    input  logic                    reset,
    input  vic20_load_pkg::dl_bus_t dl_i,
    input  logic [`VIC_MEM_AW-1:0]  tap_end_i,
    input  logic                    p2_h_i,
    input  logic [7:0]              mem_dout_i,
    input  logic                    tap_wrfull_i,
    output logic [`VIC_MEM_AW-1:0]  play_addr_o,
    output logic                    oe_o,
    output logic [7:0]              tap_data_o,
    output logic                    tap_wrreq_o,
    output logic                    tap_restart_o,
    output logic                    tap_version_o
);

    logic                   tap_dl;
    logic                   tap_dl_q;
    logic                   restart_q;
    logic                   p2_h_q;
    logic                   p2_fall;
    logic                   p2_rise;
    logic [`VIC_MEM_AW-1:0] end_addr;

    assign tap_dl        = dl_i.active && (dl_i.index == `VIC_IDX_TAP);
    assign p2_fall       = p2_h_q && !p2_h_i;
    assign p2_rise       = !p2_h_q && p2_h_i;
    assign tap_restart_o = restart_q || tap_dl;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            play_addr_o   <= `VIC_TAP_BASE;
            end_addr      <= `VIC_TAP_BASE;
            oe_o          <= 1'b0;
            tap_wrreq_o   <= 1'b0;
            tap_version_o <= 1'b0;
            restart_q     <= 1'b1;
            tap_dl_q      <= 1'b0;
            p2_h_q        <= 1'b0;
        end else begin
            restart_q   <= 1'b0;
            tap_dl_q    <= tap_dl;
            p2_h_q      <= p2_h_i;
            tap_wrreq_o <= 1'b0;

            // Start a read as the CPU phase ends
            if (p2_fall && !dl_i.active && play_addr_o != end_addr && !tap_wrfull_i) begin
                oe_o <= 1'b1;
            end
            if (p2_rise && oe_o) begin
                oe_o <= 1'b0;
                if (!dl_i.active) begin
                    tap_wrreq_o <= 1'b1;
                    play_addr_o <= play_addr_o + 1'b1;
                end
            end

            // End capture lags the download by a cycle to take the final store address
            if (tap_dl_q) begin
                play_addr_o <= `VIC_TAP_BASE;
                end_addr    <= tap_end_i + 1'b1;
            end
            if (tap_dl && dl_i.wr && dl_i.addr == `VIC_TAP_VER_OFS) begin
                tap_version_o <= dl_i.data[0];
            end
        end
    end

    // Memory data follows the tape address while p2 is low
    always_ff @(posedge clk_sys) begin
        if (!p2_h_i && oe_o) begin
            tap_data_o <= mem_dout_i;
        end
    end

endmodule

// File: rtl/mem_mux.sv
// Combinational; a pending load write holds the download path after active falls
`timescale 1ns/1ps
`include "vic20_load_defs.svh"

module mem_mux (
    input  logic                     dl_active_i,
    input  logic                     p2_h_i,
    input  logic                     ntsc_i,
    input  vic20_load_pkg::mem_req_t cpu_i,
    input  logic [`VIC_MEM_AW-1:0]   tape_addr_i,
    input  logic                     tape_oe_i,
    input  logic [`VIC_MEM_AW-1:0]   load_addr_i,
    input  logic [7:0]               load_data_i,
    input  logic                     load_we_i,
    output vic20_load_pkg::mem_req_t mem_o
);

    logic kernal_hit;

    // Top 8K of the CPU map holds the kernal
    assign kernal_hit = (cpu_i.addr[15:13] == 3'b111);

    always_comb begin
        mem_o = '0;
        if (dl_active_i || load_we_i) begin
            mem_o.addr = load_addr_i;
            mem_o.din  = load_data_i;
            mem_o.we   = load_we_i;
        end else if (p2_h_i) begin
            mem_o = cpu_i;
            // PAL and NTSC kernal copies differ in bit 16
            if (kernal_hit) begin
                mem_o.addr = {{(`VIC_MEM_AW-17){1'b0}}, ntsc_i, cpu_i.addr[15:0]};
            end
        end else begin
            mem_o.addr = tape_addr_i;
            mem_o.oe   = tape_oe_i;
        end
    end

endmodule

// File: rtl/vic20_loader_top.sv
// Host wr pulses one cycle per byte with index steady while active; all logic on clk_sys
`timescale 1ns/1ps
`include "vic20_load_defs.svh"

module vic20_loader_top (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  vic20_load_pkg::dl_bus_t  dl_i,
    input  logic                     no_load_addr_i,
    input  logic                     ntsc_i,
    input  logic                     p2_h_i,
    input  vic20_load_pkg::mem_req_t cpu_i,
    input  logic [7:0]               mem_dout_i,
    input  logic                     tap_wrfull_i,
    output vic20_load_pkg::mem_req_t mem_o,
    output vic20_load_pkg::conf_wr_t conf_o,
    output logic                     force_reset_o,
    output logic [7:0]               tap_data_o,
    output logic                     tap_wrreq_o,
    output logic                     tap_restart_o,
    output logic                     tap_version_o
);

    vic20_load_pkg::dl_kind_e   kind;
    vic20_load_pkg::load_addr_u prg_addr;
    logic [`VIC_MEM_AW-1:0]     tap_addr;
    logic [`VIC_MEM_AW-1:0]     target;
    logic [`VIC_MEM_AW-1:0]     play_addr;
    logic                       inject;
    logic [15:0]                inj_addr;
    logic                       ld_wr;
    logic [7:0]                 ld_data;
    logic                       internal;
    logic                       tape_oe;

    // ==============================
    // Download path
    // ==============================
    prg_loader u_prg_loader (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_i           (dl_i),
        .no_load_addr_i (no_load_addr_i),
        .kind_o         (kind),
        .prg_addr_o     (prg_addr),
        .tap_addr_o     (tap_addr),
        .inject_o       (inject),
        .inj_addr_o     (inj_addr),
        .wr_o           (ld_wr),
        .data_o         (ld_data),
        .force_reset_o  (force_reset_o)
    );

    // ROM byte positions travel registered in the load address word
    load_addr_map u_load_addr_map (
        .kind_i     (kind),
        .dl_addr_i  ({8'h00, prg_addr.word}),
        .prg_addr_i (prg_addr),
        .tap_addr_i (tap_addr),
        .inject_i   (inject),
        .inj_addr_i (inj_addr),
        .target_o   (target),
        .internal_o (internal)
    );

    // Internal targets take the config bus and everything else goes to memory
    assign conf_o = '{wr: ld_wr && internal, addr: target[15:0], data: ld_data};

    // ==============================
    // Tape and memory arbitration
    // ==============================
    tape_fetch u_tape_fetch (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_i          (dl_i),
        .tap_end_i     (tap_addr),
        .p2_h_i        (p2_h_i),
        .mem_dout_i    (mem_dout_i),
        .tap_wrfull_i  (tap_wrfull_i),
        .play_addr_o   (play_addr),
        .oe_o          (tape_oe),
        .tap_data_o    (tap_data_o),
        .tap_wrreq_o   (tap_wrreq_o),
        .tap_restart_o (tap_restart_o),
        .tap_version_o (tap_version_o)
    );

    mem_mux u_mem_mux (
        .dl_active_i (dl_i.active),
        .p2_h_i      (p2_h_i),
        .ntsc_i      (ntsc_i),
        .cpu_i       (cpu_i),
        .tape_addr_i (play_addr),
        .tape_oe_i   (tape_oe),
        .load_addr_i (target),
        .load_data_i (ld_data),
        .load_we_i   (ld_wr && !internal),
        .mem_o       (mem_o)
    );

endmodule

// File: test/vic20_loader_chk.sv
// Bound into vic20_loader_top; rules hold only outside reset
`timescale 1ns/1ps

module vic20_loader_chk (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  vic20_load_pkg::dl_bus_t  dl_i,
    input  vic20_load_pkg::mem_req_t mem_o,
    input  vic20_load_pkg::conf_wr_t conf_o,
    input  logic                     tap_wrreq_o,
    input  logic                     force_reset_o
);

    // Number of failed assertions so far
    int fail_cnt = 0;

    // A byte goes to one bus only
    a_write_excl: assert property (@(posedge clk_sys) disable iff (reset)
        !(mem_o.we && conf_o.wr))
        else begin
            $error("memory and config writes in the same cycle");
            fail_cnt++;
        end

    // Single-cycle pulses
    a_wrreq_pulse: assert property (@(posedge clk_sys) disable iff (reset)
        tap_wrreq_o |=> !tap_wrreq_o)
        else begin
            $error("tap_wrreq_o high for more than one cycle");
            fail_cnt++;
        end

    a_reset_pulse: assert property (@(posedge clk_sys) disable iff (reset)
        force_reset_o |=> !force_reset_o)
        else begin
            $error("force_reset_o high for more than one cycle");
            fail_cnt++;
        end

    a_no_tape_in_dl: assert property (@(posedge clk_sys) disable iff (reset)
        !(dl_i.active && tap_wrreq_o))
        else begin
            $error("tape byte pushed during a download");
            fail_cnt++;
        end

endmodule

bind vic20_loader_top vic20_loader_chk u_chk (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .dl_i          (dl_i),
    .mem_o         (mem_o),
    .conf_o        (conf_o),
    .tap_wrreq_o   (tap_wrreq_o),
    .force_reset_o (force_reset_o)
);

// File: test/tb_vic20_loader.sv
// Reads test/load_tests.txt from the project root; the memory model covers 256K of the 23-bit space
`timescale 1ns/1ps
`include "vic20_load_defs.svh"

module tb_vic20_loader;

    localparam int NREC = 64;
    localparam logic [15:0] INJ_ADDRS [8] = '{16'h002D, 16'h002E, 16'h002F, 16'h0030,
                                              16'h0031, 16'h0032, 16'h00AE, 16'h00AF};

    logic                     clk_sys;
    logic                     reset;
    vic20_load_pkg::dl_bus_t  dl_i;
    logic                     no_load_addr_i;
    logic                     ntsc_i;
    logic                     p2_h_i;
    vic20_load_pkg::mem_req_t cpu_i;
    logic [7:0]               mem_dout_i;
    logic                     tap_wrfull_i;
    vic20_load_pkg::mem_req_t mem_o;
    vic20_load_pkg::conf_wr_t conf_o;
    logic                     force_reset_o;
    logic [7:0]               tap_data_o;
    logic                     tap_wrreq_o;
    logic                     tap_restart_o;
    logic                     tap_version_o;

    logic [63:0] recs [0:NREC-1];
    logic [7:0]  mem [0:(1<<18)-1];
    integer      seed;
    int          cyc;
    int          limit;
    int          errors;
    int          checks;
    int          rst_cnt;
    int          rst_cyc;

    // Expected writes in order with the cycle each must appear in
    bit          exp_conf [$];
    logic [22:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          exp_cyc [$];
    logic [7:0]  tap_q [$];

    vic20_loader_top DUT (.*);

    assign mem_dout_i = mem[mem_o.addr[17:0]];

    initial clk_sys = 1'b0;
    always #50 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cyc <= cyc + 1;
        if (limit != 0 && cyc > limit) begin
            $display("Error: run stopped at cycle %0d before all tests finished", cyc);
            $display("Checks run: %0d, errors: %0d", checks, errors + 1);
            $display("Errors found");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic expect_write(bit conf, logic [22:0] addr, logic [7:0] data, int at);
        exp_conf.push_back(conf);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_cyc.push_back(at);
    endtask

    task automatic check_write();
        bit          conf;
        logic [22:0] addr;
        logic [7:0]  data;
        int          at;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("Error: write to %h seen when no write was expected", mem_o.addr);
        end else begin
            conf = exp_conf.pop_front();
            addr = exp_addr.pop_front();
            data = exp_data.pop_front();
            at   = exp_cyc.pop_front();
            checks++;
            if (conf != conf_o.wr) begin
                errors++;
                $display("Error: write for %h went to the wrong bus", addr);
            end else if (conf && conf_o.addr != addr[15:0]) begin
                errors++;
                $display("Error: conf_o.addr got %h expected %h", conf_o.addr, addr[15:0]);
            end else if (!conf && mem_o.addr != addr) begin
                errors++;
                $display("Error: mem_o.addr got %h expected %h", mem_o.addr, addr);
            end
            if (conf_o.wr && conf_o.data != data) begin
                errors++;
                $display("Error: conf_o.data got %h expected %h", conf_o.data, data);
            end else if (mem_o.we && mem_o.din != data) begin
                errors++;
                $display("Error: mem_o.din got %h expected %h", mem_o.din, data);
            end
            if (cyc != at) begin
                errors++;
                $display("Error: write for %h came in cycle %0d, not %0d", addr, cyc, at);
            end
        end
    endtask

    task automatic check_tape();
        logic [7:0] want;
        if (tap_q.size() == 0) begin
            errors++;
            $display("Error: tape byte pushed after the last stored byte");
        end else begin
            want = tap_q.pop_front();
            checks++;
            if (tap_data_o != want) begin
                errors++;
                $display("Error: tap_data_o got %h expected %h", tap_data_o, want);
            end
        end
    endtask

    // Writes, pulses and tape bytes are all sampled mid-cycle
    always @(negedge clk_sys) begin
        if (!reset) begin
            if (mem_o.we || conf_o.wr) begin
                check_write();
            end
            if (mem_o.we) begin
                mem[mem_o.addr[17:0]] = mem_o.din;
            end
            if (force_reset_o) begin
                rst_cnt++;
                rst_cyc = cyc;
            end
            if (tap_wrreq_o) begin
                check_tape();
            end
        end
    end

    // One half of a CPU cycle with a random FIFO stall
    task automatic p2_phase();
        p2_h_i       = ~p2_h_i;
        tap_wrfull_i = ($unsigned($random(seed)) % 4) == 0;
        repeat (2) next_cycle();
    endtask

    task automatic play_tape();
        while (tap_q.size() != 0) begin
            p2_phase();
        end
        // Keep toggling so any byte past the end would show up
        repeat (12) p2_phase();
        p2_h_i       = 1'b1;
        tap_wrfull_i = 1'b0;
        next_cycle();
    endtask

    task automatic run_download(inout int i);
        logic [63:0] r;
        logic [7:0]  index;
        logic        want_reset;
        logic [15:0] last_addr;
        logic [7:0]  ver;
        int          c0;
        r          = recs[i];
        i++;
        index      = r[55:48];
        want_reset = r[32];
        last_addr  = '0;
        ver        = '0;
        rst_cnt    = 0;
        no_load_addr_i = r[40];
        dl_i.index     = index;
        dl_i.active    = 1'b1;
        next_cycle();
        while (recs[i][63:56] == 8'h02) begin
            r = recs[i];
            i++;
            repeat ($unsigned($random(seed)) % 4) next_cycle();
            dl_i.wr   = 1'b1;
            dl_i.addr = {8'h00, r[55:40]};
            dl_i.data = r[39:32];
            if (r[31:28] != 4'h0) begin
                expect_write(r[29], r[22:0], r[39:32], cyc + 1);
                last_addr = r[15:0];
            end
            if (index == `VIC_IDX_TAP) begin
                tap_q.push_back(r[39:32]);
                if ({8'h00, r[55:40]} == `VIC_TAP_VER_OFS) begin
                    ver = r[39:32];
                end
                if (!tap_restart_o) begin
                    errors++;
                    $display("Error: tap_restart_o low during a TAP download");
                end
            end
            next_cycle();
            dl_i.wr = 1'b0;
        end
        next_cycle();
        dl_i.active = 1'b0;
        c0          = cyc;
        if (index == `VIC_IDX_PRG || index == `VIC_IDX_CRT) begin
            // Pointer bytes alternate low and high on every other cycle
            for (int k = 0; k < 8; k++) begin
                expect_write(1'b1, {7'h00, INJ_ADDRS[k]},
                             k[0] ? last_addr[15:8] : last_addr[7:0], c0 + 2 + 2 * k);
            end
        end
        while (exp_addr.size() != 0) begin
            next_cycle();
        end
        repeat (40) next_cycle();
        checks++;
        if (want_reset && (rst_cnt != 1 || rst_cyc != c0 + 32)) begin
            errors++;
            $display("Error: force_reset_o pulsed %0d times, last in cycle %0d, expected cycle %0d",
                     rst_cnt, rst_cyc, c0 + 32);
        end else if (!want_reset && rst_cnt != 0) begin
            errors++;
            $display("Error: force_reset_o pulsed after a load below the cartridge area");
        end
        if (index == `VIC_IDX_TAP) begin
            checks++;
            if (tap_version_o != ver[0]) begin
                errors++;
                $display("Error: tap_version_o got %h expected %h", tap_version_o, ver[0]);
            end
            play_tape();
        end
    endtask

    task automatic check_cpu(logic [63:0] r);
        ntsc_i      = r[32];
        cpu_i       = '0;
        cpu_i.addr  = {7'h00, r[55:40]};
        cpu_i.oe    = 1'b1;
        p2_h_i      = 1'b1;
        @(negedge clk_sys);
        checks++;
        if (mem_o.addr != r[22:0]) begin
            errors++;
            $display("Error: mem_o.addr got %h expected %h", mem_o.addr, r[22:0]);
        end
        if (!mem_o.oe) begin
            errors++;
            $display("Error: CPU read did not reach memory");
        end
        next_cycle();
        cpu_i.oe = 1'b0;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int i;
        int nbytes;
        seed           = 32'hdd79_5cb0;
        cyc            = 0;
        limit          = 0;
        errors         = 0;
        checks         = 0;
        rst_cnt        = 0;
        rst_cyc        = 0;
        reset          = 1'b1;
        dl_i           = '0;
        no_load_addr_i = 1'b0;
        ntsc_i         = 1'b0;
        p2_h_i         = 1'b1;
        cpu_i          = '0;
        tap_wrfull_i   = 1'b0;
        for (int a = 0; a < (1 << 18); a++) begin
            mem[a] = a[7:0] ^ a[15:8] ^ {6'h00, a[17:16]};
        end
        for (int k = 0; k < NREC; k++) begin
            recs[k] = '0;
        end
        $readmemh("test/load_tests.txt", recs);
        nbytes = 0;
        for (int k = 0; k < NREC; k++) begin
            if (recs[k][63:56] == 8'h02) begin
                nbytes++;
            end
        end
        limit = nbytes * 8 + 2000;

        repeat (3) next_cycle();
        checks++;
        if (mem_o.we || mem_o.oe || conf_o.wr || force_reset_o || tap_wrreq_o ||
            !tap_restart_o) begin
            errors++;
            $display("Error: outputs not in their reset state");
        end
        reset = 1'b0;
        next_cycle();

        i = 0;
        while (i < NREC && recs[i][63:56] != 8'h00) begin
            if (recs[i][63:56] == 8'h01) begin
                run_download(i);
            end else if (recs[i][63:56] == 8'h03) begin
                check_cpu(recs[i]);
                i++;
            end else begin
                errors++;
                $display("Error: unknown record %h in the test file", recs[i]);
                i++;
            end
        end

        repeat (4) next_cycle();
        // Bound assertion failures count as errors too
        errors = errors + DUT.u_chk.fail_cnt;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: test/load_tests.txt
// Record TT_PPPP_DD_F_0_AAAAAA: tag, position, data, dest (0 none 1 mem 2 conf), target address
// Tag 01 starts a download (PPPP = index,no-header; DD = reset due), 02 byte, 03 CPU read, 00 end
// ROM image, one byte per region, char ROM on the config bus
01_0000_00_0_0_000000
02_0000_11_1_0_000000
02_2005_22_1_0_002005
02_4010_33_1_0_00E010
02_6020_44_1_0_01E020
02_8030_55_1_0_00C030
02_A040_66_2_0_008040
// PRG with header $03FE, low RAM then main memory
01_0100_00_0_0_000000
02_0000_FE_0_0_000000
02_0001_03_0_0_000000
02_0002_A1_2_0_0003FE
02_0003_A2_2_0_0003FF
02_0004_A3_1_0_000400
02_0005_A4_1_0_000401
// PRG with header $BFFD, stops at $BFFF
01_0100_00_0_0_000000
02_0000_FD_0_0_000000
02_0001_BF_0_0_000000
02_0002_B1_1_0_00BFFD
02_0003_B2_1_0_00BFFE
02_0004_B3_1_0_00BFFF
02_0005_B4_1_0_00BFFF
// Cartridge without header from $A000, auto-reset due
01_4101_01_0_0_000000
02_0000_C1_1_0_00A000
02_0001_C2_1_0_00A001
02_0002_C3_1_0_00A002
// TAP image, version byte 01 at offset 12
01_8100_00_0_0_000000
02_0000_43_1_0_020000
02_0001_36_1_0_020001
02_0002_34_1_0_020002
02_0003_2D_1_0_020003
02_0004_54_1_0_020004
02_0005_41_1_0_020005
02_0006_50_1_0_020006
02_0007_45_1_0_020007
02_0008_2D_1_0_020008
02_0009_52_1_0_020009
02_000A_41_1_0_02000A
02_000B_57_1_0_02000B
02_000C_01_1_0_02000C
// CPU reads: kernal with NTSC, kernal with PAL, plain RAM
03_E123_01_0_0_01E123
03_E123_00_0_0_00E123
03_1234_01_0_0_001234
0000000000000000

// File: build.f
+incdir+rtl
rtl/vic20_load_pkg.sv
rtl/load_addr_map.sv
rtl/prg_loader.sv
rtl/tape_fetch.sv
rtl/mem_mux.sv
rtl/vic20_loader_top.sv
test/vic20_loader_chk.sv
test/tb_vic20_loader.sv

// File: Makefile
# Verilator build and run for the loader testbench

VERILATOR ?= verilator
TOP       ?= tb_vic20_loader
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failures"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
